// File: all.f
+incdir+common
common/flit_pkg.sv
common/mesh_pkg.sv
hdl/axis_fifo.sv
router/mesh_router.sv
hdl/deadlock_detector.sv
hdl/mesh_crossbar.sv
bench/tb_clkgen.sv
bench/mesh_crossbar_asserts.sv
bench/mesh_crossbar_tb.sv

// File: bench/mesh_crossbar_asserts.sv
`timescale 1ns/1ps

module mesh_crossbar_asserts (
  input logic                                            clk,
  input logic                                            reset,
  input logic [flit_pkg::NUM_NODES*flit_pkg::DATA_W-1:0] o_m_tdata,
  input logic [flit_pkg::NUM_NODES-1:0]                  o_m_tlast,
  input logic [flit_pkg::NUM_NODES-1:0]                  o_m_tvalid,
  input logic [flit_pkg::NUM_NODES-1:0]                  i_m_tready,
  input logic [flit_pkg::NUM_NODES-1:0]                  o_s_tready,
  input logic                                            o_deadlock
);

  localparam int NN = flit_pkg::NUM_NODES;
  localparam int W  = flit_pkg::DATA_W;

  // Outputs stay quiet during recovery
  a_no_valid_in_clear: assert property (@(posedge clk) disable iff (reset)
    o_deadlock |-> (o_m_tvalid == '0))
    else $error("terminal output valid while deadlock recovery is active");

  // Inputs are drained during recovery
  a_flush_in_clear: assert property (@(posedge clk) disable iff (reset)
    o_deadlock |-> (&o_s_tready))
    else $error("terminal input not ready while deadlock recovery is active");

  for (genvar i = 0; i < NN; i++) begin : g_lane
    a_stable_when_held: assert property (@(posedge clk) disable iff (reset || o_deadlock)
      (o_m_tvalid[i] && !i_m_tready[i]) |=>
        ($stable(o_m_tdata[i*W +: W]) && $stable(o_m_tlast[i])))
      else $error("output lane %0d changed while stalled", i);
  end

endmodule

bind mesh_crossbar mesh_crossbar_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .o_m_tdata  (o_m_tdata),
  .o_m_tlast  (o_m_tlast),
  .o_m_tvalid (o_m_tvalid),
  .i_m_tready (i_m_tready),
  .o_s_tready (o_s_tready),
  .o_deadlock (o_deadlock)
);

// File: bench/mesh_crossbar_tb.sv
`timescale 1ns/1ps
`include "mesh_cfg.svh"

module mesh_crossbar_tb;

  localparam int NN        = flit_pkg::NUM_NODES;
  localparam int W         = flit_pkg::DATA_W;
  localparam int TIMEOUT   = `MESH_DEADLOCK_TIMEOUT;
  localparam int PKTS_EACH = 8;
  // Two random rounds plus the two deadlock packets
  localparam int NUM_PKTS  = 2 * PKTS_EACH * NN + 2;
  localparam int WD_CYCLES = NUM_PKTS * 4 * 40 + 4 * TIMEOUT;

  logic            clk;
  logic            reset;
  logic [NN*W-1:0] i_s_tdata;
  logic [NN-1:0]   i_s_tlast;
  logic [NN-1:0]   i_s_tvalid;
  logic [NN-1:0]   o_s_tready;
  logic [NN*W-1:0] o_m_tdata;
  logic [NN-1:0]   o_m_tlast;
  logic [NN-1:0]   o_m_tvalid;
  logic [NN-1:0]   i_m_tready;
  logic            o_deadlock;

  integer     seed = 21;
  int         errors = 0;
  bit         check_en = 1'b1;
  bit         rand_ready = 1'b1;
  // Words are {last, data}
  logic [W:0] tx_q  [NN][$];
  logic [W:0] exp_q [NN][NN][$];
  logic [NN-1:0] in_pkt;
  logic [1:0]    cur_src [NN];

  tb_clkgen clkgen (
    .o_clk   (clk),
    .o_reset (reset)
  );

  mesh_crossbar dut (
    .clk        (clk),
    .reset      (reset),
    .i_s_tdata  (i_s_tdata),
    .i_s_tlast  (i_s_tlast),
    .i_s_tvalid (i_s_tvalid),
    .o_s_tready (o_s_tready),
    .o_m_tdata  (o_m_tdata),
    .o_m_tlast  (o_m_tlast),
    .o_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready),
    .o_deadlock (o_deadlock)
  );

  // ----------------------------------------
  // Source driver and sink ready
  // ----------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      i_s_tvalid <= '0;
      i_m_tready <= '1;
    end else begin
      for (int p = 0; p < NN; p++) begin
        if (i_s_tvalid[p] && o_s_tready[p] && tx_q[p].size() != 0) begin
          void'(tx_q[p].pop_front());
        end
        if (tx_q[p].size() != 0) begin
          i_s_tdata[p*W +: W] <= tx_q[p][0][W-1:0];
          i_s_tlast[p]        <= tx_q[p][0][W];
          i_s_tvalid[p]       <= 1'b1;
        end else begin
          i_s_tvalid[p] <= 1'b0;
        end
        // Ready withheld about a quarter of the time
        i_m_tready[p] <= !rand_ready || (($random(seed) & 3) != 0);
      end
    end
  end

  // ----------------------------------------
  // Output monitor and scoreboard
  // ----------------------------------------
  always @(posedge clk) begin
    logic [W-1:0] got_data;
    logic         got_last;
    logic [W:0]   exp_w;
    if (reset || !check_en) begin
      in_pkt = '0;
    end else begin
      for (int d = 0; d < NN; d++) begin
        if (o_m_tvalid[d] && i_m_tready[d]) begin
          got_data = o_m_tdata[d*W +: W];
          got_last = o_m_tlast[d];
          if (!in_pkt[d]) begin
            cur_src[d] = got_data[3:2];
            if (got_data[1:0] != 2'(d)) begin
              $display("ERROR o_m_tdata lane %0d header dest: expected %h, got %h",
                       d, 2'(d), got_data[1:0]);
              errors++;
            end
          end
          if (exp_q[cur_src[d]][d].size() == 0) begin
            $display("Unexpected word %h on lane %0d from source %0d", got_data, d,
                     cur_src[d]);
            errors++;
          end else begin
            exp_w = exp_q[cur_src[d]][d].pop_front();
            if (got_data != exp_w[W-1:0]) begin
              $display("ERROR o_m_tdata lane %0d: expected %h, got %h", d,
                       exp_w[W-1:0], got_data);
              errors++;
            end
            if (got_last != exp_w[W]) begin
              $display("ERROR o_m_tlast lane %0d: expected %h, got %h", d, exp_w[W],
                       got_last);
              errors++;
            end
          end
          in_pkt[d] = !got_last;
        end
      end
    end
  end

  // Random packets for every node, recorded per source and destination
  task automatic build_round();
    int len;
    int dst;
    logic [W-1:0] r;
    logic [W:0]   w;
    for (int k = 0; k < PKTS_EACH; k++) begin
      for (int p = 0; p < NN; p++) begin
        len = 1 + ($random(seed) & 3);
        dst = $random(seed) & 3;
        for (int j = 0; j < len; j++) begin
          r = W'($random(seed));
          if (j == 0) begin
            r[3:0] = {2'(p), 2'(dst)};
          end
          w = {(j == len - 1), r};
          tx_q[p].push_back(w);
          exp_q[p][dst].push_back(w);
        end
      end
    end
  endtask

  task automatic wait_drained();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int p = 0; p < NN; p++) begin
        if (tx_q[p].size() != 0 || i_s_tvalid[p]) busy = 1'b1;
        for (int d = 0; d < NN; d++) begin
          if (exp_q[p][d].size() != 0) busy = 1'b1;
        end
      end
    end
  endtask

  task automatic deadlock_scenario();
    int cycles;
    int idle;
    rand_ready = 1'b0;
    check_en   = 1'b0;
    // Node 0 opens a worm towards node 3 and never closes it
    tx_q[0].push_back({1'b0, 16'h0A53});
    while (tx_q[0].size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    for (int k = 0; k < 32; k++) begin
      tx_q[1].push_back({(k == 31), (k == 0) ? 16'h0B57 : W'(k)});
    end
    cycles = 0;
    while (!o_deadlock && cycles <= 2 * TIMEOUT + 10) begin
      @(posedge clk);
      cycles++;
    end
    if (!o_deadlock) begin
      $display("Deadlock was not detected within %0d cycles", 2 * TIMEOUT + 10);
      errors++;
    end else begin
      tx_q[1].delete();
      idle = 0;
      while (o_deadlock && idle <= TIMEOUT + 2) begin
        @(posedge clk);
        if (o_deadlock && o_s_tready != '1) begin
          $display("ERROR o_s_tready: expected %h, got %h", {NN{1'b1}}, o_s_tready);
          errors++;
        end
        if (i_s_tvalid != '0) idle = 0;
        else idle++;
      end
      if (o_deadlock) begin
        $display("Deadlock recovery did not release after the inputs went idle");
        errors++;
      end
    end
    // Model starts over after the network was cleared
    for (int s = 0; s < NN; s++) begin
      tx_q[s].delete();
      for (int d = 0; d < NN; d++) exp_q[s][d].delete();
    end
    rand_ready = 1'b1;
    repeat (2) @(posedge clk);
    check_en = 1'b1;
  endtask

  initial begin
    i_s_tdata  = '0;
    i_s_tlast  = '0;
    i_s_tvalid = '0;
    i_m_tready = '1;
    wait (reset === 1'b0);
    @(posedge clk);
    build_round();
    wait_drained();
    deadlock_scenario();
    build_round();
    wait_drained();
    repeat (5) @(posedge clk);
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WD_CYCLES * 20);
    $display("Timeout: the run did not finish within %0d cycles, %0d errors so far",
             WD_CYCLES, errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter real PERIOD_NS   = 20.0,
  parameter int  RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk   = 1'b0;
    o_reset = 1'b1;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

  // Reset held for a fixed number of rising edges
  initial begin
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

// File: common/flit_pkg.sv
`include "mesh_cfg.svh"

package flit_pkg;

  localparam int DATA_W    = `MESH_DATA_WIDTH;
  localparam int NUM_NODES = `MESH_DIM_SIZE * `MESH_DIM_SIZE;
  localparam int NODE_W    = $clog2(NUM_NODES);

  // Header field positions
  localparam int DEST_LSB = 0;
  localparam int SRC_LSB  = NODE_W;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [NODE_W-1:0] node_id_t;

  // One word plus its end of packet marker
  typedef struct packed {
    logic  last;
    data_t data;
  } flit_t;

  function automatic node_id_t get_dest(input data_t hdr);
    return hdr[DEST_LSB +: NODE_W];
  endfunction

  function automatic node_id_t get_src(input data_t hdr);
    return hdr[SRC_LSB +: NODE_W];
  endfunction

endpackage

// File: common/mesh_cfg.svh
`ifndef MESH_CFG_SVH
`define MESH_CFG_SVH

// ----------------------------------------
// Mesh size and buffering
// ----------------------------------------

// Routers along one side of the mesh
`define MESH_DIM_SIZE 2

// Width of one word on every link
`define MESH_DATA_WIDTH 16

// Input FIFO depth as log2 of words
`define MESH_BUFF_LOG2 2

// ----------------------------------------
// Deadlock recovery
// ----------------------------------------

// Cycles of stall before a clear, and idle cycles before release
`define MESH_DEADLOCK_TIMEOUT 64

`endif

// File: common/mesh_pkg.sv
`include "mesh_cfg.svh"

package mesh_pkg;

  localparam int DIM_SIZE  = `MESH_DIM_SIZE;
  localparam int COORD_W   = $clog2(DIM_SIZE);
  localparam int NUM_PORTS = 5;

  // Router port index, TERM is the local terminal
  typedef enum logic [2:0] {
    TERM,
    WEST,
    EAST,
    NORTH,
    SOUTH
  } port_e;

  typedef logic [COORD_W-1:0] coord_t;

  // Node n sits in column n mod DIM_SIZE
  function automatic coord_t node_to_x(input flit_pkg::node_id_t node);
    return coord_t'(node % DIM_SIZE);
  endfunction

  // and in row n div DIM_SIZE
  function automatic coord_t node_to_y(input flit_pkg::node_id_t node);
    return coord_t'(node / DIM_SIZE);
  endfunction

endpackage

// File: hdl/axis_fifo.sv
`timescale 1ns/1ps

module axis_fifo #(
  parameter type T          = flit_pkg::flit_t,
  parameter int  DEPTH_LOG2 = 2
) (
  input  logic clk,
  input  logic reset,
  // Write side
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  // Read side
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  T                    mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  push;
  logic                  pop;

  assign o_ready = (count != (DEPTH_LOG2 + 1)'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign push = i_valid & o_ready;
  assign pop  = o_valid & i_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers wrap naturally at the power of two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/deadlock_detector.sv
`timescale 1ns/1ps
`include "mesh_cfg.svh"

module deadlock_detector (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [flit_pkg::NUM_NODES-1:0] i_s_tvalid,
  input  logic [flit_pkg::NUM_NODES-1:0] i_s_tready,
  input  logic [flit_pkg::NUM_NODES-1:0] i_m_tvalid,
  input  logic [flit_pkg::NUM_NODES-1:0] i_m_tready,
  output logic                           o_clear
);

  localparam int TIMEOUT = `MESH_DEADLOCK_TIMEOUT;
  localparam int CNT_W   = $clog2(TIMEOUT + 1);

  logic             s_stalled;
  logic             m_stalled;
  logic [CNT_W-1:0] stall_cnt;
  logic [CNT_W-1:0] recover_cnt;

  // Network looks stuck when an input waits and no output does
  assign s_stalled = |(i_s_tvalid & ~i_s_tready);
  assign m_stalled = |(i_m_tvalid & ~i_m_tready);

  // ----------------------------------------
  // Stall timer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset || !(s_stalled && !m_stalled)) begin
      stall_cnt <= CNT_W'(TIMEOUT);
    end else if (stall_cnt != '0) begin
      stall_cnt <= stall_cnt - 1'b1;
    end
  end

  // ----------------------------------------
  // Recovery timer
  // ----------------------------------------
  // Any input activity during recovery restarts the idle wait
  always_ff @(posedge clk) begin
    if (reset) begin
      recover_cnt <= '0;
    end else if (o_clear) begin
      if (|i_s_tvalid) begin
        recover_cnt <= CNT_W'(TIMEOUT);
      end else begin
        recover_cnt <= recover_cnt - 1'b1;
      end
    end else if (stall_cnt == '0) begin
      recover_cnt <= CNT_W'(TIMEOUT);
    end
  end

  assign o_clear = (recover_cnt != '0);

endmodule

// File: hdl/mesh_crossbar.sv
`timescale 1ns/1ps

module mesh_crossbar (
  input  logic                                           clk,
  input  logic                                           reset,
  // Terminal inputs, node p in lane p
  input  logic [flit_pkg::NUM_NODES*flit_pkg::DATA_W-1:0] i_s_tdata,
  input  logic [flit_pkg::NUM_NODES-1:0]                  i_s_tlast,
  input  logic [flit_pkg::NUM_NODES-1:0]                  i_s_tvalid,
  output logic [flit_pkg::NUM_NODES-1:0]                  o_s_tready,
  // Terminal outputs
  output logic [flit_pkg::NUM_NODES*flit_pkg::DATA_W-1:0] o_m_tdata,
  output logic [flit_pkg::NUM_NODES-1:0]                  o_m_tlast,
  output logic [flit_pkg::NUM_NODES-1:0]                  o_m_tvalid,
  input  logic [flit_pkg::NUM_NODES-1:0]                  i_m_tready,
  output logic                                           o_deadlock
);

  localparam int N  = mesh_pkg::DIM_SIZE;
  localparam int NN = flit_pkg::NUM_NODES;
  localparam int W  = flit_pkg::DATA_W;

  logic          clear;
  logic [NN-1:0] term_s_ready;
  logic [NN-1:0] term_m_valid;

  // Neighbour link signals as driven by the router at [y][x]
  flit_pkg::data_t lk_data  [mesh_pkg::WEST:mesh_pkg::SOUTH][N][N];
  logic            lk_last  [mesh_pkg::WEST:mesh_pkg::SOUTH][N][N];
  logic            lk_valid [mesh_pkg::WEST:mesh_pkg::SOUTH][N][N];
  // Ready of each router's neighbour input
  logic            lk_ready [mesh_pkg::WEST:mesh_pkg::SOUTH][N][N];

  // ----------------------------------------
  // Router grid
  // ----------------------------------------
  for (genvar y = 0; y < N; y++) begin : g_row
    for (genvar x = 0; x < N; x++) begin : g_col
      localparam int P  = y * N + x;
      localparam int XW = (x + N - 1) % N;
      localparam int XE = (x + 1) % N;
      localparam int YN = (y + N - 1) % N;
      localparam int YS = (y + 1) % N;
      // Edge ports see no traffic in and always accept out
      localparam bit HAS_W = (x != 0);
      localparam bit HAS_E = (x != N - 1);
      localparam bit HAS_N = (y != 0);
      localparam bit HAS_S = (y != N - 1);

      mesh_router #(
        .XB_ADDR_X (mesh_pkg::coord_t'(x)),
        .XB_ADDR_Y (mesh_pkg::coord_t'(y))
      ) rtr_i (
        .clk             (clk),
        .reset           (reset | clear),
        .i_s_term_tdata  (i_s_tdata[P*W +: W]),
        .i_s_term_tlast  (i_s_tlast[P]),
        .i_s_term_tvalid (i_s_tvalid[P]),
        .o_s_term_tready (term_s_ready[P]),
        .o_m_term_tdata  (o_m_tdata[P*W +: W]),
        .o_m_term_tlast  (o_m_tlast[P]),
        .o_m_term_tvalid (term_m_valid[P]),
        .i_m_term_tready (i_m_tready[P]),
        .i_s_wst_tdata   (HAS_W ? lk_data[mesh_pkg::EAST][y][XW] : '0),
        .i_s_wst_tlast   (HAS_W & lk_last[mesh_pkg::EAST][y][XW]),
        .i_s_wst_tvalid  (HAS_W & lk_valid[mesh_pkg::EAST][y][XW]),
        .o_s_wst_tready  (lk_ready[mesh_pkg::WEST][y][x]),
        .o_m_wst_tdata   (lk_data[mesh_pkg::WEST][y][x]),
        .o_m_wst_tlast   (lk_last[mesh_pkg::WEST][y][x]),
        .o_m_wst_tvalid  (lk_valid[mesh_pkg::WEST][y][x]),
        .i_m_wst_tready  (!HAS_W | lk_ready[mesh_pkg::EAST][y][XW]),
        .i_s_est_tdata   (HAS_E ? lk_data[mesh_pkg::WEST][y][XE] : '0),
        .i_s_est_tlast   (HAS_E & lk_last[mesh_pkg::WEST][y][XE]),
        .i_s_est_tvalid  (HAS_E & lk_valid[mesh_pkg::WEST][y][XE]),
        .o_s_est_tready  (lk_ready[mesh_pkg::EAST][y][x]),
        .o_m_est_tdata   (lk_data[mesh_pkg::EAST][y][x]),
        .o_m_est_tlast   (lk_last[mesh_pkg::EAST][y][x]),
        .o_m_est_tvalid  (lk_valid[mesh_pkg::EAST][y][x]),
        .i_m_est_tready  (!HAS_E | lk_ready[mesh_pkg::WEST][y][XE]),
        .i_s_nor_tdata   (HAS_N ? lk_data[mesh_pkg::SOUTH][YN][x] : '0),
        .i_s_nor_tlast   (HAS_N & lk_last[mesh_pkg::SOUTH][YN][x]),
        .i_s_nor_tvalid  (HAS_N & lk_valid[mesh_pkg::SOUTH][YN][x]),
        .o_s_nor_tready  (lk_ready[mesh_pkg::NORTH][y][x]),
        .o_m_nor_tdata   (lk_data[mesh_pkg::NORTH][y][x]),
        .o_m_nor_tlast   (lk_last[mesh_pkg::NORTH][y][x]),
        .o_m_nor_tvalid  (lk_valid[mesh_pkg::NORTH][y][x]),
        .i_m_nor_tready  (!HAS_N | lk_ready[mesh_pkg::SOUTH][YN][x]),
        .i_s_sou_tdata   (HAS_S ? lk_data[mesh_pkg::NORTH][YS][x] : '0),
        .i_s_sou_tlast   (HAS_S & lk_last[mesh_pkg::NORTH][YS][x]),
        .i_s_sou_tvalid  (HAS_S & lk_valid[mesh_pkg::NORTH][YS][x]),
        .o_s_sou_tready  (lk_ready[mesh_pkg::SOUTH][y][x]),
        .o_m_sou_tdata   (lk_data[mesh_pkg::SOUTH][y][x]),
        .o_m_sou_tlast   (lk_last[mesh_pkg::SOUTH][y][x]),
        .o_m_sou_tvalid  (lk_valid[mesh_pkg::SOUTH][y][x]),
        .i_m_sou_tready  (!HAS_S | lk_ready[mesh_pkg::NORTH][YS][x])
      );
    end
  end

  // ----------------------------------------
  // Deadlock recovery
  // ----------------------------------------
  // Inputs drain and outputs go quiet while routers are cleared
  assign o_s_tready = term_s_ready | {NN{clear}};
  assign o_m_tvalid = term_m_valid & ~{NN{clear}};
  assign o_deadlock = clear;

  deadlock_detector dl_det_i (
    .clk        (clk),
    .reset      (reset),
    .i_s_tvalid (i_s_tvalid),
    .i_s_tready (o_s_tready),
    .i_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready),
    .o_clear    (clear)
  );

endmodule

// File: router/mesh_router.sv
`timescale 1ns/1ps
`include "mesh_cfg.svh"

module mesh_router #(
  parameter mesh_pkg::coord_t XB_ADDR_X = '0,
  parameter mesh_pkg::coord_t XB_ADDR_Y = '0
) (
  input  logic            clk,
  input  logic            reset,
  // Terminal
  input  flit_pkg::data_t i_s_term_tdata,
  input  logic            i_s_term_tlast,
  input  logic            i_s_term_tvalid,
  output logic            o_s_term_tready,
  output flit_pkg::data_t o_m_term_tdata,
  output logic            o_m_term_tlast,
  output logic            o_m_term_tvalid,
  input  logic            i_m_term_tready,
  // West
  input  flit_pkg::data_t i_s_wst_tdata,
  input  logic            i_s_wst_tlast,
  input  logic            i_s_wst_tvalid,
  output logic            o_s_wst_tready,
  output flit_pkg::data_t o_m_wst_tdata,
  output logic            o_m_wst_tlast,
  output logic            o_m_wst_tvalid,
  input  logic            i_m_wst_tready,
  // East
  input  flit_pkg::data_t i_s_est_tdata,
  input  logic            i_s_est_tlast,
  input  logic            i_s_est_tvalid,
  output logic            o_s_est_tready,
  output flit_pkg::data_t o_m_est_tdata,
  output logic            o_m_est_tlast,
  output logic            o_m_est_tvalid,
  input  logic            i_m_est_tready,
  // North
  input  flit_pkg::data_t i_s_nor_tdata,
  input  logic            i_s_nor_tlast,
  input  logic            i_s_nor_tvalid,
  output logic            o_s_nor_tready,
  output flit_pkg::data_t o_m_nor_tdata,
  output logic            o_m_nor_tlast,
  output logic            o_m_nor_tvalid,
  input  logic            i_m_nor_tready,
  // South
  input  flit_pkg::data_t i_s_sou_tdata,
  input  logic            i_s_sou_tlast,
  input  logic            i_s_sou_tvalid,
  output logic            o_s_sou_tready,
  output flit_pkg::data_t o_m_sou_tdata,
  output logic            o_m_sou_tlast,
  output logic            o_m_sou_tvalid,
  input  logic            i_m_sou_tready
);

  localparam int NP = mesh_pkg::NUM_PORTS;

  // Highest priority first, Y inputs above X inputs above terminal
  localparam mesh_pkg::port_e PRIO [NP] = '{
    mesh_pkg::NORTH, mesh_pkg::SOUTH, mesh_pkg::WEST, mesh_pkg::EAST, mesh_pkg::TERM
  };

  // All per-port arrays are indexed by mesh_pkg::port_e
  flit_pkg::flit_t in_flit  [NP];
  flit_pkg::flit_t head     [NP];
  flit_pkg::flit_t out_flit [NP];
  mesh_pkg::port_e route    [NP];
  mesh_pkg::port_e sel      [NP];
  mesh_pkg::port_e owner    [NP];
  logic [NP-1:0]   req      [NP];
  logic [NP-1:0]   in_valid;
  logic [NP-1:0]   in_ready;
  logic [NP-1:0]   head_valid;
  logic [NP-1:0]   head_ready;
  logic [NP-1:0]   out_valid;
  logic [NP-1:0]   out_ready;
  logic [NP-1:0]   sel_ok;
  logic [NP-1:0]   locked;
  logic [NP-1:0]   at_sop;

  // ----------------------------------------
  // Port mapping
  // ----------------------------------------
  assign in_flit[mesh_pkg::TERM]  = '{last: i_s_term_tlast, data: i_s_term_tdata};
  assign in_flit[mesh_pkg::WEST]  = '{last: i_s_wst_tlast, data: i_s_wst_tdata};
  assign in_flit[mesh_pkg::EAST]  = '{last: i_s_est_tlast, data: i_s_est_tdata};
  assign in_flit[mesh_pkg::NORTH] = '{last: i_s_nor_tlast, data: i_s_nor_tdata};
  assign in_flit[mesh_pkg::SOUTH] = '{last: i_s_sou_tlast, data: i_s_sou_tdata};

  assign in_valid  = {i_s_sou_tvalid, i_s_nor_tvalid, i_s_est_tvalid, i_s_wst_tvalid,
                      i_s_term_tvalid};
  assign out_ready = {i_m_sou_tready, i_m_nor_tready, i_m_est_tready, i_m_wst_tready,
                      i_m_term_tready};
  assign {o_s_sou_tready, o_s_nor_tready, o_s_est_tready, o_s_wst_tready,
          o_s_term_tready} = in_ready;
  assign {o_m_sou_tvalid, o_m_nor_tvalid, o_m_est_tvalid, o_m_wst_tvalid,
          o_m_term_tvalid} = out_valid;

  assign o_m_term_tdata = out_flit[mesh_pkg::TERM].data;
  assign o_m_term_tlast = out_flit[mesh_pkg::TERM].last;
  assign o_m_wst_tdata  = out_flit[mesh_pkg::WEST].data;
  assign o_m_wst_tlast  = out_flit[mesh_pkg::WEST].last;
  assign o_m_est_tdata  = out_flit[mesh_pkg::EAST].data;
  assign o_m_est_tlast  = out_flit[mesh_pkg::EAST].last;
  assign o_m_nor_tdata  = out_flit[mesh_pkg::NORTH].data;
  assign o_m_nor_tlast  = out_flit[mesh_pkg::NORTH].last;
  assign o_m_sou_tdata  = out_flit[mesh_pkg::SOUTH].data;
  assign o_m_sou_tlast  = out_flit[mesh_pkg::SOUTH].last;

  for (genvar i = 0; i < NP; i++) begin : g_in_fifo
    axis_fifo #(
      .T          (flit_pkg::flit_t),
      .DEPTH_LOG2 (`MESH_BUFF_LOG2)
    ) fifo_i (
      .clk     (clk),
      .reset   (reset),
      .i_data  (in_flit[i]),
      .i_valid (in_valid[i]),
      .o_ready (in_ready[i]),
      .o_data  (head[i]),
      .o_valid (head_valid[i]),
      .i_ready (head_ready[i])
    );
  end

  // ----------------------------------------
  // Route computation, X first then Y
  // ----------------------------------------
  function automatic mesh_pkg::port_e xy_route(input flit_pkg::node_id_t dest);
    mesh_pkg::coord_t dx;
    mesh_pkg::coord_t dy;
    dx = mesh_pkg::node_to_x(dest);
    dy = mesh_pkg::node_to_y(dest);
    if (dx > XB_ADDR_X) return mesh_pkg::EAST;
    if (dx < XB_ADDR_X) return mesh_pkg::WEST;
    if (dy > XB_ADDR_Y) return mesh_pkg::SOUTH;
    if (dy < XB_ADDR_Y) return mesh_pkg::NORTH;
    return mesh_pkg::TERM;
  endfunction

  // Only a head that starts a packet may ask for an output
  always_comb begin
    for (int i = 0; i < NP; i++) begin
      route[i] = xy_route(flit_pkg::get_dest(head[i].data));
    end
    for (int o = 0; o < NP; o++) begin
      for (int i = 0; i < NP; i++) begin
        req[o][i] = head_valid[i] & at_sop[i] & (route[i] == mesh_pkg::port_e'(o));
      end
    end
  end

  // ----------------------------------------
  // Switch allocation
  // ----------------------------------------
  always_comb begin
    for (int o = 0; o < NP; o++) begin
      sel[o]    = owner[o];
      sel_ok[o] = locked[o];
      if (!locked[o]) begin
        // Walk up from lowest priority so the highest requester wins
        for (int k = NP - 1; k >= 0; k--) begin
          if (req[o][PRIO[k]]) begin
            sel[o]    = PRIO[k];
            sel_ok[o] = 1'b1;
          end
        end
      end
      out_flit[o]  = head[sel[o]];
      out_valid[o] = sel_ok[o] & head_valid[sel[o]];
    end
  end

  always_comb begin
    head_ready = '0;
    for (int o = 0; o < NP; o++) begin
      if (sel_ok[o] && out_ready[o]) begin
        head_ready[sel[o]] = 1'b1;
      end
    end
  end

  // Output stays with its owner from grant until last leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      locked <= '0;
      at_sop <= '1;
      for (int o = 0; o < NP; o++) begin
        owner[o] <= mesh_pkg::TERM;
      end
    end else begin
      for (int i = 0; i < NP; i++) begin
        if (head_valid[i] && head_ready[i]) begin
          at_sop[i] <= head[i].last;
        end
      end
      for (int o = 0; o < NP; o++) begin
        if (out_valid[o] && out_ready[o] && out_flit[o].last) begin
          locked[o] <= 1'b0;
        end else if (sel_ok[o]) begin
          locked[o] <= 1'b1;
          owner[o]  <= sel[o];
        end
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the mesh crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mesh_crossbar_tb \
  -f all.f \
  -o sim_mesh

./obj_dir/sim_mesh > sim.log 2>&1 || true
cat sim.log

# Pass only if the testbench reported success
grep -q "^TB PASSED$" sim.log
